// File: verilog/csr_pkg.sv
// CSR package for the machine-mode CSR file
// Holds addresses, operation codes, register layouts, reset values
// and write masks shared by the access logic and the register blocks

package csr_pkg;

  ////////////////////////////////////////
  // Widths and addresses
  ////////////////////////////////////////

  localparam int unsigned XLEN       = 32;
  localparam int unsigned CSR_ADDR_W = 12;

  localparam logic [CSR_ADDR_W-1:0] CSR_MSTATUS  = 12'h300;
  localparam logic [CSR_ADDR_W-1:0] CSR_MIE      = 12'h304;
  localparam logic [CSR_ADDR_W-1:0] CSR_MTVEC    = 12'h305;
  localparam logic [CSR_ADDR_W-1:0] CSR_MSCRATCH = 12'h340;
  localparam logic [CSR_ADDR_W-1:0] CSR_MEPC     = 12'h341;
  localparam logic [CSR_ADDR_W-1:0] CSR_MCAUSE   = 12'h342;

  // Encoding follows funct3[1:0] of the Zicsr instructions
  typedef enum logic [1:0] {
    CSR_OP_READ  = 2'b00,
    CSR_OP_WRITE = 2'b01,
    CSR_OP_SET   = 2'b10,
    CSR_OP_CLEAR = 2'b11
  } csr_op_e;

  ////////////////////////////////////////
  // Register layouts
  ////////////////////////////////////////

  typedef struct packed {
    logic [18:0] rsv_31_13;
    logic [1:0]  mpp;
    logic [2:0]  rsv_10_8;
    logic        mpie;
    logic [2:0]  rsv_6_4;
    logic        mie;
    logic [2:0]  rsv_2_0;
  } mstatus_t;

  // The mpp and mpie fields mirror the ones in mstatus
  typedef struct packed {
    logic        irq;
    logic        rsv_30;
    logic [1:0]  mpp;
    logic        mpie;
    logic [15:0] rsv_26_11;
    logic [10:0] exccode;
  } mcause_t;

  // One written word, seen as whichever layout the address selects
  typedef union packed {
    mstatus_t as_mstatus;
    mcause_t  as_mcause;
  } csr_word_u;

  ////////////////////////////////////////
  // Privilege, modes and masks
  ////////////////////////////////////////

  localparam logic [1:0] PRIV_M = 2'b11;

  localparam logic [1:0] MTVEC_MODE_DIRECT   = 2'b00;
  localparam logic [1:0] MTVEC_MODE_VECTORED = 2'b01;

  // Software, timer and external interrupt enables
  localparam logic [XLEN-1:0] MIE_WRITE_MASK = 32'h0000_0888;

  ////////////////////////////////////////
  // Reset values
  ////////////////////////////////////////

  localparam mstatus_t MSTATUS_RESET = '{mpp: PRIV_M, default: '0};

  localparam logic [XLEN-1:0] MTVEC_RESET = '0;

endpackage

// File: verilog/csr_access.sv
// CSR access logic
// Decodes the CSR instruction in writeback, returns the old register
// value, computes the new value and raises one write strobe per register

`timescale 1ns/1ps

module csr_access
  import csr_pkg::*;
(
  input  logic                  clk,
  input  logic                  arst_n_i,

  input  logic [CSR_ADDR_W-1:0] addr_i,
  input  csr_op_e               op_i,
  input  logic [XLEN-1:0]       wdata_i,
  input  logic                  valid_i,
  input  logic                  halt_i,
  input  logic                  kill_i,

  input  logic [XLEN-1:0]       mstatus_q_i,
  input  logic [XLEN-1:0]       mcause_q_i,
  input  logic [XLEN-1:0]       mepc_q_i,
  input  logic [XLEN-1:0]       mtvec_q_i,
  input  logic [XLEN-1:0]       mie_q_i,
  input  logic [XLEN-1:0]       mscratch_q_i,

  output logic [XLEN-1:0]       rdata_o,
  output logic                  illegal_o,
  output logic [XLEN-1:0]       wnew_o,
  output logic                  we_mstatus_o,
  output logic                  we_mcause_o,
  output logic                  we_mepc_o,
  output logic                  we_mtvec_o,
  output logic                  we_mie_o,
  output logic                  we_mscratch_o
);

  logic [XLEN-1:0] old_value;
  logic            addr_legal;
  logic            set_or_clear;
  logic            write_en;

  ////////////////////////////////////////
  // Address decode and read multiplexer
  ////////////////////////////////////////

  always_comb begin
    addr_legal = 1'b1;
    case (addr_i)
      CSR_MSTATUS:  old_value = mstatus_q_i;
      CSR_MCAUSE:   old_value = mcause_q_i;
      CSR_MEPC:     old_value = mepc_q_i;
      CSR_MTVEC:    old_value = mtvec_q_i;
      CSR_MIE:      old_value = mie_q_i;
      CSR_MSCRATCH: old_value = mscratch_q_i;
      default: begin
        old_value  = '0;
        addr_legal = 1'b0;
      end
    endcase
  end

  assign rdata_o   = valid_i ? old_value : '0;
  assign illegal_o = valid_i && !addr_legal;

  ////////////////////////////////////////
  // New value and write strobes
  ////////////////////////////////////////

  always_comb begin
    case (op_i)
      CSR_OP_WRITE: wnew_o = wdata_i;
      CSR_OP_SET:   wnew_o = old_value | wdata_i;
      CSR_OP_CLEAR: wnew_o = old_value & ~wdata_i;
      default:      wnew_o = old_value;
    endcase
  end

  assign set_or_clear = (op_i == CSR_OP_SET) || (op_i == CSR_OP_CLEAR);

  // A set or clear with a zero operand is a pure read
  assign write_en = valid_i && !halt_i && !kill_i && addr_legal &&
                    (op_i != CSR_OP_READ) && !(set_or_clear && (wdata_i == '0));

  assign we_mstatus_o  = write_en && (addr_i == CSR_MSTATUS);
  assign we_mcause_o   = write_en && (addr_i == CSR_MCAUSE);
  assign we_mepc_o     = write_en && (addr_i == CSR_MEPC);
  assign we_mtvec_o    = write_en && (addr_i == CSR_MTVEC);
  assign we_mie_o      = write_en && (addr_i == CSR_MIE);
  assign we_mscratch_o = write_en && (addr_i == CSR_MSCRATCH);

  ////////////////////////////////////////
  // Assertions
  ////////////////////////////////////////

  // The stage must not change state while it is halted or killed
  a_no_write_halt_kill:
  assert property (@(posedge clk) disable iff (!arst_n_i)
                   (halt_i || kill_i) |->
                   !(we_mstatus_o || we_mcause_o || we_mepc_o ||
                     we_mtvec_o || we_mie_o || we_mscratch_o))
    else $error("CSR write strobe while writeback is halted or killed");

  a_no_write_zero_operand:
  assert property (@(posedge clk) disable iff (!arst_n_i)
                   (set_or_clear && (wdata_i == '0)) |->
                   !(we_mstatus_o || we_mcause_o || we_mepc_o ||
                     we_mtvec_o || we_mie_o || we_mscratch_o))
    else $error("CSR write strobe for set or clear with zero operand");

  a_strobe_onehot:
  assert property (@(posedge clk) disable iff (!arst_n_i)
                   $onehot0({we_mstatus_o, we_mcause_o, we_mepc_o,
                             we_mtvec_o, we_mie_o, we_mscratch_o}))
    else $error("More than one CSR write strobe active");

endmodule

// File: verilog/csr_trap_regs.sv
// Trap CSRs: mstatus, mcause and mepc
// Handles trap entry and mret, and keeps the mpp and mpie fields
// of mstatus and mcause in one place so they always agree

`timescale 1ns/1ps

module csr_trap_regs
  import csr_pkg::*;
(
  input  logic            clk,
  input  logic            arst_n_i,

  input  logic [XLEN-1:0] wnew_i,
  input  logic            we_mstatus_i,
  input  logic            we_mcause_i,
  input  logic            we_mepc_i,

  input  logic            trap_i,
  input  logic            trap_irq_i,
  input  logic [10:0]     trap_code_i,
  input  logic [XLEN-1:0] trap_pc_i,
  input  logic            mret_i,

  output logic [XLEN-1:0] mstatus_q_o,
  output logic [XLEN-1:0] mcause_q_o,
  output logic [XLEN-1:0] mepc_q_o,
  output logic            global_ie_o
);

  csr_word_u       wword;
  mstatus_t        mstatus_view;
  mcause_t         mcause_view;

  logic            mie_q;
  logic            mpie_q;
  logic            irq_q;
  logic [10:0]     exccode_q;
  logic [XLEN-1:0] mepc_q;

  assign wword = wnew_i;

  ////////////////////////////////////////
  // State update
  ////////////////////////////////////////

  // Trap and mret take priority over any CSR write in the same cycle
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      mie_q     <= MSTATUS_RESET.mie;
      mpie_q    <= MSTATUS_RESET.mpie;
      irq_q     <= 1'b0;
      exccode_q <= '0;
      mepc_q    <= '0;
    end else if (trap_i) begin
      mpie_q    <= mie_q;
      mie_q     <= 1'b0;
      irq_q     <= trap_irq_i;
      exccode_q <= trap_code_i;
      mepc_q    <= {trap_pc_i[XLEN-1:1], 1'b0};
    end else if (mret_i) begin
      mie_q  <= mpie_q;
      mpie_q <= 1'b1;
    end else begin
      if (we_mstatus_i) begin
        mie_q  <= wword.as_mstatus.mie;
        mpie_q <= wword.as_mstatus.mpie;
      end
      if (we_mcause_i) begin
        irq_q     <= wword.as_mcause.irq;
        exccode_q <= wword.as_mcause.exccode;
        mpie_q    <= wword.as_mcause.mpie;
      end
      // Instruction addresses are at least halfword aligned
      if (we_mepc_i) begin
        mepc_q <= {wnew_i[XLEN-1:1], 1'b0};
      end
    end
  end

  ////////////////////////////////////////
  // Register views
  ////////////////////////////////////////

  // Only machine mode exists, so mpp is fixed
  always_comb begin
    mstatus_view      = '0;
    mstatus_view.mie  = mie_q;
    mstatus_view.mpie = mpie_q;
    mstatus_view.mpp  = PRIV_M;

    mcause_view         = '0;
    mcause_view.irq     = irq_q;
    mcause_view.mpp     = PRIV_M;
    mcause_view.mpie    = mpie_q;
    mcause_view.exccode = exccode_q;
  end

  assign mstatus_q_o = mstatus_view;
  assign mcause_q_o  = mcause_view;
  assign mepc_q_o    = mepc_q;
  assign global_ie_o = mie_q;

  ////////////////////////////////////////
  // Assertions
  ////////////////////////////////////////

  a_mpp_machine:
  assert property (@(posedge clk) disable iff (!arst_n_i)
                   (mstatus_view.mpp == PRIV_M) && (mcause_view.mpp == PRIV_M))
    else $error("mpp does not read as machine mode");

  a_mpie_mirror:
  assert property (@(posedge clk) disable iff (!arst_n_i)
                   mstatus_view.mpie == mcause_view.mpie)
    else $error("mstatus.mpie and mcause.mpie disagree");

  a_trap_clears_ie:
  assert property (@(posedge clk) disable iff (!arst_n_i)
                   trap_i |=> !global_ie_o)
    else $error("Global interrupt enable still set after trap entry");

endmodule

// File: verilog/csr_config_regs.sv
// Configuration CSRs: mtvec, mie and mscratch
// Legalizes the mtvec mode and keeps only the implemented mie bits

`timescale 1ns/1ps

module csr_config_regs
  import csr_pkg::*;
(
  input  logic            clk,
  input  logic            arst_n_i,

  input  logic [XLEN-1:0] wnew_i,
  input  logic            we_mtvec_i,
  input  logic            we_mie_i,
  input  logic            we_mscratch_i,

  output logic [XLEN-1:0] mtvec_q_o,
  output logic [XLEN-1:0] mie_q_o,
  output logic [XLEN-1:0] mscratch_q_o,
  output logic [XLEN-1:0] trap_vector_o,
  output logic            mode_vectored_o,
  output logic [XLEN-1:0] mie_o
);

  logic [XLEN-1:0] mtvec_q;
  logic [XLEN-1:0] mie_q;
  logic [XLEN-1:0] mscratch_q;
  logic [1:0]      mode_next;

  // Reserved modes are ignored and the previous mode stays
  assign mode_next = ((wnew_i[1:0] == MTVEC_MODE_DIRECT) ||
                      (wnew_i[1:0] == MTVEC_MODE_VECTORED)) ? wnew_i[1:0] : mtvec_q[1:0];

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      mtvec_q    <= MTVEC_RESET;
      mie_q      <= '0;
      mscratch_q <= '0;
    end else begin
      if (we_mtvec_i) begin
        mtvec_q <= {wnew_i[XLEN-1:2], mode_next};
      end
      if (we_mie_i) begin
        mie_q <= wnew_i & MIE_WRITE_MASK;
      end
      if (we_mscratch_i) begin
        mscratch_q <= wnew_i;
      end
    end
  end

  assign mtvec_q_o    = mtvec_q;
  assign mie_q_o      = mie_q;
  assign mscratch_q_o = mscratch_q;

  // Base address for the trap handler, mode bits stripped
  assign trap_vector_o   = {mtvec_q[XLEN-1:2], 2'b00};
  assign mode_vectored_o = (mtvec_q[1:0] == MTVEC_MODE_VECTORED);
  assign mie_o           = mie_q;

  a_mtvec_mode_legal:
  assert property (@(posedge clk) disable iff (!arst_n_i)
                   (mtvec_q[1:0] == MTVEC_MODE_DIRECT) ||
                   (mtvec_q[1:0] == MTVEC_MODE_VECTORED))
    else $error("mtvec holds a reserved mode");

endmodule

// File: verilog/csr_file_top.sv
// Machine-mode CSR file, top level
// Connects the writeback access logic to the trap and configuration
// register blocks

`timescale 1ns/1ps

module csr_file_top
  import csr_pkg::*;
(
  input  logic                  clk,
  input  logic                  arst_n_i,

  input  logic                  valid_i,
  input  logic                  halt_i,
  input  logic                  kill_i,
  input  logic [CSR_ADDR_W-1:0] addr_i,
  input  csr_op_e               op_i,
  input  logic [XLEN-1:0]       wdata_i,

  input  logic                  trap_i,
  input  logic                  trap_irq_i,
  input  logic [10:0]           trap_code_i,
  input  logic [XLEN-1:0]       trap_pc_i,
  input  logic                  mret_i,

  output logic [XLEN-1:0]       rdata_o,
  output logic                  illegal_o,
  output logic [XLEN-1:0]       mepc_o,
  output logic [XLEN-1:0]       trap_vector_o,
  output logic                  mode_vectored_o,
  output logic [XLEN-1:0]       mie_o,
  output logic                  global_ie_o
);

  logic [XLEN-1:0] wnew;
  logic            we_mstatus;
  logic            we_mcause;
  logic            we_mepc;
  logic            we_mtvec;
  logic            we_mie;
  logic            we_mscratch;

  logic [XLEN-1:0] mstatus_q;
  logic [XLEN-1:0] mcause_q;
  logic [XLEN-1:0] mepc_q;
  logic [XLEN-1:0] mtvec_q;
  logic [XLEN-1:0] mie_q;
  logic [XLEN-1:0] mscratch_q;

  csr_access u_access (
    .clk           (clk),
    .arst_n_i      (arst_n_i),
    .addr_i        (addr_i),
    .op_i          (op_i),
    .wdata_i       (wdata_i),
    .valid_i       (valid_i),
    .halt_i        (halt_i),
    .kill_i        (kill_i),
    .mstatus_q_i   (mstatus_q),
    .mcause_q_i    (mcause_q),
    .mepc_q_i      (mepc_q),
    .mtvec_q_i     (mtvec_q),
    .mie_q_i       (mie_q),
    .mscratch_q_i  (mscratch_q),
    .rdata_o       (rdata_o),
    .illegal_o     (illegal_o),
    .wnew_o        (wnew),
    .we_mstatus_o  (we_mstatus),
    .we_mcause_o   (we_mcause),
    .we_mepc_o     (we_mepc),
    .we_mtvec_o    (we_mtvec),
    .we_mie_o      (we_mie),
    .we_mscratch_o (we_mscratch)
  );

  // Trap and mret pulses override CSR writes inside this block
  csr_trap_regs u_trap_regs (
    .clk          (clk),
    .arst_n_i     (arst_n_i),
    .wnew_i       (wnew),
    .we_mstatus_i (we_mstatus),
    .we_mcause_i  (we_mcause),
    .we_mepc_i    (we_mepc),
    .trap_i       (trap_i),
    .trap_irq_i   (trap_irq_i),
    .trap_code_i  (trap_code_i),
    .trap_pc_i    (trap_pc_i),
    .mret_i       (mret_i),
    .mstatus_q_o  (mstatus_q),
    .mcause_q_o   (mcause_q),
    .mepc_q_o     (mepc_q),
    .global_ie_o  (global_ie_o)
  );

  csr_config_regs u_config_regs (
    .clk             (clk),
    .arst_n_i        (arst_n_i),
    .wnew_i          (wnew),
    .we_mtvec_i      (we_mtvec),
    .we_mie_i        (we_mie),
    .we_mscratch_i   (we_mscratch),
    .mtvec_q_o       (mtvec_q),
    .mie_q_o         (mie_q),
    .mscratch_q_o    (mscratch_q),
    .trap_vector_o   (trap_vector_o),
    .mode_vectored_o (mode_vectored_o),
    .mie_o           (mie_o)
  );

  assign mepc_o = mepc_q;

endmodule

// File: tb/csr_ref_model.svh
// Reference model of the machine-mode CSR file
// Shadow registers follow the architectural rules of the CSR file and
// give the expected read data and illegal flag for any address

`ifndef CSR_REF_MODEL_SVH
`define CSR_REF_MODEL_SVH

logic            ref_gie;
logic            ref_mpie;
logic            ref_irq;
logic [10:0]     ref_code;
logic [XLEN-1:0] ref_mepc;
logic [XLEN-1:0] ref_mtvec;
logic [XLEN-1:0] ref_mie;
logic [XLEN-1:0] ref_mscratch;

function automatic void reset_model();
  ref_gie      = 1'b0;
  ref_mpie     = 1'b0;
  ref_irq      = 1'b0;
  ref_code     = '0;
  ref_mepc     = '0;
  ref_mtvec    = '0;
  ref_mie      = '0;
  ref_mscratch = '0;
endfunction

function automatic logic expected_illegal(input logic [CSR_ADDR_W-1:0] addr);
  return !(addr inside {CSR_MSTATUS, CSR_MCAUSE, CSR_MEPC, CSR_MTVEC, CSR_MIE, CSR_MSCRATCH});
endfunction

// Only machine mode exists, so both mpp fields read as 2'b11
function automatic logic [XLEN-1:0] expected_rdata(input logic [CSR_ADDR_W-1:0] addr);
  case (addr)
    CSR_MSTATUS:  return {19'b0, 2'b11, 3'b0, ref_mpie, 3'b0, ref_gie, 3'b0};
    CSR_MCAUSE:   return {ref_irq, 1'b0, 2'b11, ref_mpie, 16'b0, ref_code};
    CSR_MEPC:     return ref_mepc;
    CSR_MTVEC:    return ref_mtvec;
    CSR_MIE:      return ref_mie;
    CSR_MSCRATCH: return ref_mscratch;
    default:      return '0;
  endcase
endfunction

function automatic void apply_csr_op(input logic [CSR_ADDR_W-1:0] addr, input csr_op_e op,
                                     input logic [XLEN-1:0] wdata);
  logic [XLEN-1:0] old_val;
  logic [XLEN-1:0] new_val;
  logic [1:0]      mode;
  old_val = expected_rdata(addr);
  if (expected_illegal(addr) || (op == CSR_OP_READ)) return;
  // Set and clear with nothing to change are plain reads
  if ((op != CSR_OP_WRITE) && (wdata == '0)) return;
  case (op)
    CSR_OP_SET:   new_val = old_val | wdata;
    CSR_OP_CLEAR: new_val = old_val & ~wdata;
    default:      new_val = wdata;
  endcase
  case (addr)
    CSR_MSTATUS: begin
      ref_gie  = new_val[3];
      ref_mpie = new_val[7];
    end
    CSR_MCAUSE: begin
      ref_irq  = new_val[31];
      ref_mpie = new_val[27];
      ref_code = new_val[10:0];
    end
    CSR_MEPC: ref_mepc = {new_val[XLEN-1:1], 1'b0};
    CSR_MTVEC: begin
      mode      = (new_val[1:0] < 2'd2) ? new_val[1:0] : ref_mtvec[1:0];
      ref_mtvec = {new_val[XLEN-1:2], mode};
    end
    CSR_MIE:  ref_mie = new_val & 32'h0000_0888;
    default:  ref_mscratch = new_val;
  endcase
endfunction

function automatic void apply_trap(input logic irq, input logic [10:0] code,
                                   input logic [XLEN-1:0] pc);
  ref_mpie = ref_gie;
  ref_gie  = 1'b0;
  ref_irq  = irq;
  ref_code = code;
  ref_mepc = {pc[XLEN-1:1], 1'b0};
endfunction

function automatic void apply_mret();
  ref_gie  = ref_mpie;
  ref_mpie = 1'b1;
endfunction

`endif

// File: tb/csr_file_tb.sv
// Testbench for the machine-mode CSR file
// Drives CSR instructions and trap pulses, compares every read and the
// state outputs with the reference model and reports per test

`timescale 1ns/1ps

module csr_file_tb
  import csr_pkg::*;
();

  // Cycles taken by each test and the run limit of twice their sum
  localparam int RESET_CYC   = 15;
  localparam int OPS_CYC     = 400;
  localparam int SUPPR_CYC   = 16;
  localparam int MIRROR_CYC  = 8;
  localparam int TRAP_CYC    = 28;
  localparam int ILLEGAL_CYC = 8;
  localparam int TIMEOUT_CYC = 2 * (RESET_CYC + OPS_CYC + SUPPR_CYC + MIRROR_CYC +
                                    TRAP_CYC + ILLEGAL_CYC);

  logic                  clk;
  logic                  arst_n_i;
  logic                  valid_i;
  logic                  halt_i;
  logic                  kill_i;
  logic [CSR_ADDR_W-1:0] addr_i;
  csr_op_e               op_i;
  logic [XLEN-1:0]       wdata_i;
  logic                  trap_i;
  logic                  trap_irq_i;
  logic [10:0]           trap_code_i;
  logic [XLEN-1:0]       trap_pc_i;
  logic                  mret_i;
  logic [XLEN-1:0]       rdata_o;
  logic                  illegal_o;
  logic [XLEN-1:0]       mepc_o;
  logic [XLEN-1:0]       trap_vector_o;
  logic                  mode_vectored_o;
  logic [XLEN-1:0]       mie_o;
  logic                  global_ie_o;

  logic                  check_en;
  logic [XLEN-1:0]       exp_rdata;
  logic                  exp_illegal;
  logic [XLEN-1:0]       rnd_word;
  logic [CSR_ADDR_W-1:0] sel_addr;
  csr_op_e               sel_op;
  int                    cycle_cnt;
  int                    check_cnt;
  int                    err_cnt;
  int                    test_err_start;
  int                    tests_passed;
  int                    tests_failed;

  `include "csr_ref_model.svh"

  csr_file_top uut (
    .clk             (clk),
    .arst_n_i        (arst_n_i),
    .valid_i         (valid_i),
    .halt_i          (halt_i),
    .kill_i          (kill_i),
    .addr_i          (addr_i),
    .op_i            (op_i),
    .wdata_i         (wdata_i),
    .trap_i          (trap_i),
    .trap_irq_i      (trap_irq_i),
    .trap_code_i     (trap_code_i),
    .trap_pc_i       (trap_pc_i),
    .mret_i          (mret_i),
    .rdata_o         (rdata_o),
    .illegal_o       (illegal_o),
    .mepc_o          (mepc_o),
    .trap_vector_o   (trap_vector_o),
    .mode_vectored_o (mode_vectored_o),
    .mie_o           (mie_o),
    .global_ie_o     (global_ie_o)
  );

  always #2 clk = ~clk;

  ////////////////////////////////////////
  // Comparison and run limit
  ////////////////////////////////////////

  task automatic compare_word(input string name, input logic [XLEN-1:0] got,
                              input logic [XLEN-1:0] exp);
    check_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("ERROR at %0t: %s is %08h, expected %08h", $time, name, got, exp);
    end
  endtask

  // Outputs settle well before the falling edge
  always @(negedge clk) begin
    if (check_en) begin
      compare_word("rdata_o", rdata_o, exp_rdata);
      compare_word("illegal_o", {31'b0, illegal_o}, {31'b0, exp_illegal});
      compare_word("mepc_o", mepc_o, ref_mepc);
      compare_word("trap_vector_o", trap_vector_o, {ref_mtvec[XLEN-1:2], 2'b00});
      compare_word("mode_vectored_o", {31'b0, mode_vectored_o},
                   {31'b0, (ref_mtvec[1:0] == 2'b01)});
      compare_word("mie_o", mie_o, ref_mie);
      compare_word("global_ie_o", {31'b0, global_ie_o}, {31'b0, ref_gie});
    end
  end

  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt >= TIMEOUT_CYC) begin
      $display("Run timed out after %0d cycles", cycle_cnt);
      $display("STATUS: FAIL");
      $finish;
    end
  end

  ////////////////////////////////////////
  // Stimulus tasks
  ////////////////////////////////////////

  task automatic run_csr_op(input logic [CSR_ADDR_W-1:0] addr, input csr_op_e op,
                            input logic [XLEN-1:0] wdata, input logic halt, input logic kill);
    addr_i      = addr;
    op_i        = op;
    wdata_i     = wdata;
    halt_i      = halt;
    kill_i      = kill;
    valid_i     = 1'b1;
    exp_rdata   = expected_rdata(addr);
    exp_illegal = expected_illegal(addr);
    check_en    = 1'b1;
    @(posedge clk);
    #0.5;
    check_en = 1'b0;
    valid_i  = 1'b0;
    halt_i   = 1'b0;
    kill_i   = 1'b0;
    if (!halt && !kill) begin
      apply_csr_op(addr, op, wdata);
    end
  endtask

  task automatic read_csr(input logic [CSR_ADDR_W-1:0] addr);
    run_csr_op(addr, CSR_OP_READ, '0, 1'b0, 1'b0);
  endtask

  task automatic pulse_trap(input logic irq, input logic [10:0] code, input logic [XLEN-1:0] pc);
    trap_i      = 1'b1;
    trap_irq_i  = irq;
    trap_code_i = code;
    trap_pc_i   = pc;
    @(posedge clk);
    #0.5;
    trap_i = 1'b0;
    apply_trap(irq, code, pc);
  endtask

  task automatic pulse_mret();
    mret_i = 1'b1;
    @(posedge clk);
    #0.5;
    mret_i = 1'b0;
    apply_mret();
  endtask

  // Zero-operand set and clear, then halted and killed writes
  task automatic check_suppressed_ops(input logic [CSR_ADDR_W-1:0] addr);
    run_csr_op(addr, CSR_OP_SET, '0, 1'b0, 1'b0);
    run_csr_op(addr, CSR_OP_CLEAR, '0, 1'b0, 1'b0);
    run_csr_op(addr, CSR_OP_WRITE, $urandom, 1'b1, 1'b0);
    run_csr_op(addr, CSR_OP_SET, $urandom, 1'b0, 1'b1);
    read_csr(addr);
  endtask

  task automatic finish_test(input string name);
    if (err_cnt == test_err_start) begin
      tests_passed++;
      $display("Test %s: passed", name);
    end else begin
      tests_failed++;
      $display("Test %s: failed with %0d errors", name, err_cnt - test_err_start);
    end
    test_err_start = err_cnt;
  endtask

  ////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////

  initial begin
    void'($urandom(81));
    clk         = 1'b0;
    arst_n_i    = 1'b0;
    valid_i     = 1'b0;
    halt_i      = 1'b0;
    kill_i      = 1'b0;
    addr_i      = '0;
    op_i        = CSR_OP_READ;
    wdata_i     = '0;
    trap_i      = 1'b0;
    trap_irq_i  = 1'b0;
    trap_code_i = '0;
    trap_pc_i   = '0;
    mret_i      = 1'b0;
    check_en    = 1'b0;
    exp_rdata   = '0;
    exp_illegal = 1'b0;
    reset_model();
    repeat (8) @(posedge clk);
    #0.5;
    arst_n_i = 1'b1;
    @(posedge clk);
    #0.5;

    read_csr(CSR_MSTATUS);
    read_csr(CSR_MCAUSE);
    read_csr(CSR_MEPC);
    read_csr(CSR_MTVEC);
    read_csr(CSR_MIE);
    read_csr(CSR_MSCRATCH);
    finish_test("reset values");

    for (int i = 0; i < 200; i++) begin
      rnd_word = $urandom;
      case (rnd_word % 3)
        0:       sel_addr = CSR_MSCRATCH;
        1:       sel_addr = CSR_MIE;
        default: sel_addr = CSR_MEPC;
      endcase
      case ((rnd_word / 3) % 3)
        0:       sel_op = CSR_OP_WRITE;
        1:       sel_op = CSR_OP_SET;
        default: sel_op = CSR_OP_CLEAR;
      endcase
      run_csr_op(sel_addr, sel_op, $urandom, 1'b0, 1'b0);
      read_csr(sel_addr);
    end
    finish_test("random operations");

    run_csr_op(CSR_MSCRATCH, CSR_OP_WRITE, 32'hA5A5_5A5A, 1'b0, 1'b0);
    check_suppressed_ops(CSR_MSCRATCH);
    check_suppressed_ops(CSR_MEPC);
    check_suppressed_ops(CSR_MIE);
    finish_test("suppressed writes");

    // mpie through mcause, then back through mstatus, with mpp cleared each time
    run_csr_op(CSR_MCAUSE, CSR_OP_WRITE, 32'h0800_0005, 1'b0, 1'b0);
    read_csr(CSR_MSTATUS);
    run_csr_op(CSR_MSTATUS, CSR_OP_WRITE, 32'h0000_0008, 1'b0, 1'b0);
    read_csr(CSR_MCAUSE);
    run_csr_op(CSR_MSTATUS, CSR_OP_CLEAR, 32'h0000_1800, 1'b0, 1'b0);
    run_csr_op(CSR_MCAUSE, CSR_OP_CLEAR, 32'h3000_0000, 1'b0, 1'b0);
    read_csr(CSR_MSTATUS);
    read_csr(CSR_MCAUSE);
    finish_test("field mirroring");

    for (int i = 0; i < 4; i++) begin
      // Odd passes trap with mie set and mpie clear, even passes the other way round
      run_csr_op(CSR_MSTATUS, CSR_OP_WRITE, i[0] ? 32'h0000_0008 : 32'h0000_0080,
                 1'b0, 1'b0);
      rnd_word = $urandom;
      pulse_trap(rnd_word[31], rnd_word[10:0], $urandom);
      read_csr(CSR_MEPC);
      read_csr(CSR_MCAUSE);
      read_csr(CSR_MSTATUS);
      pulse_mret();
      read_csr(CSR_MSTATUS);
    end
    finish_test("trap and return");

    run_csr_op(12'h7C0, CSR_OP_WRITE, $urandom, 1'b0, 1'b0);
    read_csr(12'h3A0);
    run_csr_op(CSR_MTVEC, CSR_OP_WRITE, 32'h8000_0102, 1'b0, 1'b0);
    read_csr(CSR_MTVEC);
    run_csr_op(CSR_MTVEC, CSR_OP_WRITE, 32'h1000_0041, 1'b0, 1'b0);
    read_csr(CSR_MTVEC);
    run_csr_op(CSR_MTVEC, CSR_OP_WRITE, 32'h2000_0083, 1'b0, 1'b0);
    read_csr(CSR_MTVEC);
    finish_test("illegal access and mtvec");

    $display("Tests passed: %0d, failed: %0d, checks: %0d, errors: %0d",
             tests_passed, tests_failed, check_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

// File: csr_file.f
+incdir+tb
verilog/csr_pkg.sv
verilog/csr_access.sv
verilog/csr_trap_regs.sv
verilog/csr_config_regs.sv
verilog/csr_file_top.sv
tb/csr_file_tb.sv

// File: Bender.yml
package:
  name: csr_file

sources:
  - verilog/csr_pkg.sv
  - verilog/csr_access.sv
  - verilog/csr_trap_regs.sv
  - verilog/csr_config_regs.sv
  - verilog/csr_file_top.sv
  - target: test
    include_dirs:
      - tb
    files:
      - tb/csr_file_tb.sv
